// ==== include/mem_defines.svh ====
// memory subsystem parameters
// address width, ram size, peripheral location and response delay
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus address width in bits
`define MEM_ADDR_W 32

// ram depth in 32-bit words, byte limit is four times this
`define RAM_WORDS 512

// word address of the peripheral data register
`define MMIO_ADDR 923920

// cycles from peripheral request to done, at least 1
`define MMIO_WAIT 5

`endif

// ==== source/mem_pkg.sv ====
// memory subsystem types
// access size codes from func3 and the two views of a data word
package mem_pkg;

    // func3 encodings for loads and stores
    // unlisted codes fall back to a full word
    typedef enum logic [2:0] {
        SZ_B  = 3'd0,
        SZ_H  = 3'd1,
        SZ_W  = 3'd2,
        SZ_BU = 3'd4,
        SZ_HU = 3'd5
    } access_size_t;

    // one 32-bit word seen as bytes or as halves
    // index 0 is the low byte or low half
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

endpackage

// ==== source/mem_bus_if.sv ====
// memory bus between the handler and the address decoder
// level request held until a one-cycle done strobe
`timescale 1ns/100ps
`include "mem_defines.svh"

interface mem_bus_if;

    // request side, held until done
    logic                   read_req;
    logic                   write_req;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            wdata;

    // completion side, rdata valid with done
    logic [31:0]            rdata;
    logic                   done;

    // handler end
    modport master (
        output read_req,
        output write_req,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    // decoder end
    modport slave (
        input  read_req,
        input  write_req,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// ==== source/ls_format.sv ====
// load and store data formatting by access size
// stores are narrowed with zero fill, loads are sign or zero extended
`timescale 1ns/100ps

module ls_format (
    input  mem_pkg::access_size_t func3,
    input  logic [31:0]           store_src,
    input  logic [31:0]           load_src,
    output logic [31:0]           store_word,
    output logic [31:0]           load_word
);
    import mem_pkg::*;

    data_word_u ld;

    // same load word, read through both views below
    assign ld = load_src;

    // store narrowing
    always_comb begin
        case (func3)
            // sb, low byte only
            SZ_B: store_word = {24'b0, store_src[7:0]};
            // sh, low half only
            SZ_H: store_word = {16'b0, store_src[15:0]};
            // sw and anything else
            default: store_word = store_src;
        endcase
    end

    // load extension
    always_comb begin
        case (func3)
            // lb, sign from bit 7
            SZ_B: begin
                load_word = {{24{ld.bytes[0][7]}}, ld.bytes[0]};
            end
            // lh, sign from bit 15
            SZ_H: begin
                load_word = {{16{ld.halves[0][15]}}, ld.halves[0]};
            end
            // lbu
            SZ_BU: begin
                load_word = {24'b0, ld.bytes[0]};
            end
            // lhu
            SZ_HU: begin
                load_word = {16'b0, ld.halves[0]};
            end
            // lw, plus the unused codes
            default: begin
                load_word = ld;
            end
        endcase
    end

endmodule

// ==== source/mem_handler.sv ====
// memory handler for the single-cycle core
// fetches the instruction at pc, then runs the load or store,
// then pulses counter_on so the core moves to the next instruction
`timescale 1ns/100ps

module mem_handler (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [31:0]           pc,
    input  logic [31:0]           mem_address,
    input  logic [31:0]           store_data,
    input  logic                  read,
    input  logic                  write,
    input  mem_pkg::access_size_t func3,
    mem_bus_if.master             bus,
    output logic [31:0]           instruction,
    output logic [31:0]           load_data,
    output logic                  counter_on
);

    typedef enum logic [2:0] {
        INC,
        FETCH,
        FWAIT,
        LORS,
        LWAIT,
        REGOP
    } state_t;

    state_t      state;

    // request levels
    logic        rd_q;
    logic        wr_q;

    // request payload
    logic [31:0] addr_q;
    logic [31:0] wdata_q;

    // formatted data from ls_format
    logic [31:0] store_word;
    logic [31:0] load_word;

    ls_format u_fmt (
        .func3      (func3),
        .store_src  (store_data),
        .load_src   (bus.rdata),
        .store_word (store_word),
        .load_word  (load_word)
    );

    assign bus.read_req  = rd_q;
    assign bus.write_req = wr_q;
    assign bus.addr      = addr_q;
    assign bus.wdata     = wdata_q;

    // one cycle per instruction, high straight out of reset
    assign counter_on = (state == INC);

    // sequencer and request levels
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state       <= INC;
            rd_q        <= 1'b0;
            wr_q        <= 1'b0;
            instruction <= '0;
            load_data   <= '0;
        end else begin
            case (state)
                INC: begin
                    state <= FETCH;
                end
                // start the instruction read
                FETCH: begin
                    rd_q  <= 1'b1;
                    state <= FWAIT;
                end
                FWAIT: begin
                    if (bus.done) begin
                        rd_q        <= 1'b0;
                        instruction <= bus.rdata;
                        state       <= LORS;
                    end
                end
                // write wins if both are set
                LORS: begin
                    if (write) begin
                        wr_q  <= 1'b1;
                        state <= LWAIT;
                    end else if (read) begin
                        rd_q  <= 1'b1;
                        state <= LWAIT;
                    end else begin
                        state <= INC;
                    end
                end
                LWAIT: begin
                    if (bus.done) begin
                        if (rd_q) begin
                            rd_q      <= 1'b0;
                            load_data <= load_word;
                            state     <= REGOP;
                        end else begin
                            wr_q  <= 1'b0;
                            state <= INC;
                        end
                    end
                end
                // register write-back slot for loads
                REGOP: begin
                    state <= INC;
                end
                default: begin
                    state <= INC;
                end
            endcase
        end
    end

    // address and store word, captured when a request starts
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            addr_q <= pc;
        end else if (state == LORS && (read || write)) begin
            addr_q  <= mem_address;
            wdata_q <= store_word;
        end
    end

    // a single access kind at a time on the bus
    a_one_req : assert property (@(posedge clk) disable iff (!nrst)
        !(bus.read_req && bus.write_req));

    // an open request keeps its level and address until the decoder answers
    a_req_hold : assert property (@(posedge clk) disable iff (!nrst)
        ((bus.read_req || bus.write_req) && !bus.done)
        |=> ((bus.read_req || bus.write_req) && $stable(bus.addr)));

endmodule

// ==== source/mem_decode.sv ====
// address decoder for the memory bus
// steers each request to the ram, the peripheral register or unmapped
// space and returns the matching data and done
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_decode (
    input  logic        clk,
    input  logic        nrst,
    mem_bus_if.slave    bus,
    output logic        ram_sel,
    output logic        mmio_sel,
    output logic        wr,
    output logic [31:0] addr,
    output logic [31:0] wdata,
    input  logic [31:0] ram_rdata,
    input  logic [31:0] mmio_rdata,
    input  logic        ram_done,
    input  logic        mmio_done
);

    // first byte address past the ram
    localparam logic [31:0] RAM_LIMIT = 32'(`RAM_WORDS * 4);

    logic req;
    logic is_ram;
    logic is_mmio;

    assign req     = bus.read_req | bus.write_req;
    assign is_ram  = (bus.addr < RAM_LIMIT);
    assign is_mmio = (bus.addr == 32'(`MMIO_ADDR));

    // select drops on the done cycle, no second access
    assign ram_sel  = req & is_ram & ~ram_done;
    assign mmio_sel = req & is_mmio & ~mmio_done;

    assign wr    = bus.write_req;
    assign addr  = bus.addr;
    assign wdata = bus.wdata;

    // return path
    always_comb begin
        if (is_ram) begin
            bus.rdata = ram_rdata;
            bus.done  = ram_done;
        end else if (is_mmio) begin
            bus.rdata = mmio_rdata;
            bus.done  = mmio_done;
        end else begin
            // unmapped, reads zero and finishes at once
            bus.rdata = '0;
            bus.done  = req;
        end
    end

    // targets only answer an open request
    a_done_req : assert property (@(posedge clk) disable iff (!nrst)
        bus.done |-> req);

endmodule

// ==== source/data_ram.sv ====
// data ram, 32-bit words, single port
// read data and done come one cycle after the select
`timescale 1ns/100ps
`include "mem_defines.svh"

module data_ram (
    input  logic        clk,
    input  logic        nrst,
    input  logic        sel,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [31:0]      mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;

    // word index, byte offset dropped
    assign idx = addr[IDX_W+1:2];

    // array access
    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr) begin
                mem[idx] <= wdata;
            end
            // old word on a write, not used by the handler
            rdata <= mem[idx];
        end
    end

    // fixed one-cycle response
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            done <= 1'b0;
        end else begin
            done <= sel;
        end
    end

endmodule

// ==== source/mmio_reg.sv ====
// peripheral data register standing in for the i2c device
// counts down a fixed delay before it answers a read or write
`timescale 1ns/100ps
`include "mem_defines.svh"

module mmio_reg (
    input  logic        clk,
    input  logic        nrst,
    input  logic        sel,
    input  logic        wr,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        done
);

    localparam int CNT_W = $clog2(`MMIO_WAIT + 1);

    logic             active;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      data_q;
    logic             hit;
    logic             fire;

    // new access, only when idle and at our address
    assign hit  = sel && (addr == 32'(`MMIO_ADDR)) && !active;
    // countdown expired
    assign fire = active && (cnt == '0);

    assign done  = fire;
    assign rdata = data_q;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            active <= 1'b0;
            cnt    <= '0;
            data_q <= '0;
        end else if (hit) begin
            // done lands MMIO_WAIT cycles after this one
            active <= 1'b1;
            cnt    <= CNT_W'(`MMIO_WAIT - 1);
        end else if (fire) begin
            active <= 1'b0;
            // write takes effect with done
            if (wr) begin
                data_q <= wdata;
            end
        end else if (active) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== source/mem_top.sv ====
// memory side top level
// handler, bus, decoder, data ram and peripheral register
`timescale 1ns/100ps

module mem_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [31:0]           pc,
    input  logic [31:0]           mem_address,
    input  logic [31:0]           store_data,
    input  logic                  read,
    input  logic                  write,
    input  mem_pkg::access_size_t func3,
    output logic [31:0]           instruction,
    output logic [31:0]           load_data,
    output logic                  counter_on
);

    // decoder to target wiring
    logic        ram_sel;
    logic        mmio_sel;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] ram_rdata;
    logic [31:0] mmio_rdata;
    logic        ram_done;
    logic        mmio_done;

    mem_bus_if bus ();

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .mem_address (mem_address),
        .store_data  (store_data),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .bus         (bus.master),
        .instruction (instruction),
        .load_data   (load_data),
        .counter_on  (counter_on)
    );

    mem_decode u_decode (
        .clk        (clk),
        .nrst       (nrst),
        .bus        (bus.slave),
        .ram_sel    (ram_sel),
        .mmio_sel   (mmio_sel),
        .wr         (wr),
        .addr       (addr),
        .wdata      (wdata),
        .ram_rdata  (ram_rdata),
        .mmio_rdata (mmio_rdata),
        .ram_done   (ram_done),
        .mmio_done  (mmio_done)
    );

    data_ram u_ram (
        .clk   (clk),
        .nrst  (nrst),
        .sel   (ram_sel),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdata (ram_rdata),
        .done  (ram_done)
    );

    mmio_reg u_mmio (
        .clk   (clk),
        .nrst  (nrst),
        .sel   (mmio_sel),
        .wr    (wr),
        .addr  (addr),
        .wdata (wdata),
        .rdata (mmio_rdata),
        .done  (mmio_done)
    );

endmodule

// ==== tests/tb_mem_top.sv ====
// testbench for the memory side top level
// random ram stores and loads, fetch, peripheral and unmapped accesses,
// checked against a word model by concurrent assertions at each counter_on
`timescale 1ns/100ps
`include "mem_defines.svh"

module tb_mem_top;
    import mem_pkg::*;

    // cycles between counter_on pulses for ram traffic
    localparam int NOP_LEN   = 5;
    localparam int STORE_LEN = 7;
    localparam int LOAD_LEN  = 8;

    // how the instruction length is checked
    localparam int LEN_ANY    = 0;
    localparam int LEN_EXACT  = 1;
    localparam int LEN_LONGER = 2;

    // test sizes
    localparam int PACE_N  = 4;
    localparam int ROUNDS  = 4;
    localparam int FETCH_N = 3;
    localparam int MMIO_N  = 2;
    localparam int UNMAP_N = 3;

    // cycle budget of all tests, peripheral waits included
    localparam int BUDGET = 10 + NOP_LEN + PACE_N * NOP_LEN
        + ROUNDS * (3 * (STORE_LEN + LOAD_LEN) + STORE_LEN + 5 * LOAD_LEN)
        + FETCH_N * (STORE_LEN + NOP_LEN)
        + MMIO_N * (STORE_LEN + LOAD_LEN + 2 * `MMIO_WAIT)
        + UNMAP_N * LOAD_LEN;
    localparam int LIMIT = 4 * BUDGET;

    logic         clk;
    logic         nrst;
    logic [31:0]  pc;
    logic [31:0]  mem_address;
    logic [31:0]  store_data;
    logic         read;
    logic         write;
    access_size_t func3;
    logic [31:0]  instruction;
    logic [31:0]  load_data;
    logic         counter_on;

    // expectations for the instruction in flight
    int           len_mode;
    int           exp_len;
    logic         chk_load;
    logic [31:0]  exp_load;
    logic         chk_instr;
    logic [31:0]  exp_instr;

    // bookkeeping
    int           gap;
    int           cycles;
    int           errors;
    int           tests;
    int           failed;
    int           err_mark;
    logic [31:0]  seed;

    // reference storage
    logic [31:0]  ram_model [`RAM_WORDS];
    logic [31:0]  mmio_model;

    mem_top uut (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .mem_address (mem_address),
        .store_data  (store_data),
        .read        (read),
        .write       (write),
        .func3       (func3),
        .instruction (instruction),
        .load_data   (load_data),
        .counter_on  (counter_on)
    );

    always #10 clk = ~clk;

    // cycles since the last counter_on
    always @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            gap <= 0;
        end else if (counter_on) begin
            gap <= 1;
        end else begin
            gap <= gap + 1;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: counter_on stopped arriving, run ended after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // idle handler and cleared outputs right out of reset
    a_reset_state : assert property (@(posedge clk)
        $rose(nrst) |-> (counter_on && !uut.bus.read_req && !uut.bus.write_req
                         && instruction == '0 && load_data == '0))
        else begin
            errors++;
            $display("Mismatch at %0t: handler not idle with cleared outputs after reset",
                     $time);
        end

    // ram instructions have a fixed length
    a_pace : assert property (@(posedge clk) disable iff (!nrst)
        (counter_on && len_mode == LEN_EXACT) |-> gap == exp_len)
        else begin
            errors++;
            $display("Mismatch at %0t: %0d cycles between counter_on pulses, expected %0d",
                     $time, $sampled(gap), $sampled(exp_len));
        end

    // peripheral waits outlast a ram access
    a_slow : assert property (@(posedge clk) disable iff (!nrst)
        (counter_on && len_mode == LEN_LONGER) |-> gap > exp_len)
        else begin
            errors++;
            $display("Mismatch at %0t: peripheral access took %0d cycles, ram takes %0d",
                     $time, $sampled(gap), $sampled(exp_len));
        end

    a_load : assert property (@(posedge clk) disable iff (!nrst)
        (counter_on && chk_load) |-> load_data === exp_load)
        else begin
            errors++;
            $display("Mismatch at %0t: load_data %h, expected %h",
                     $time, $sampled(load_data), $sampled(exp_load));
        end

    a_fetch : assert property (@(posedge clk) disable iff (!nrst)
        (counter_on && chk_instr) |-> instruction === exp_instr)
        else begin
            errors++;
            $display("Mismatch at %0t: instruction %h, expected %h",
                     $time, $sampled(instruction), $sampled(exp_instr));
        end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper lcg bits, low bits repeat quickly
    function automatic logic [31:0] rand_ram_addr();
        return ((lcg_next() >> 8) % `RAM_WORDS) << 2;
    endfunction

    // odd rounds set bits 7 and 15 so both sign cases come up
    function automatic logic [31:0] rand_value(input int r);
        logic [31:0] v;
        v = lcg_next();
        if (r[0]) begin
            return v | 32'h0000_8080;
        end
        return v & ~32'h0000_8080;
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'(a[31:2]) % `RAM_WORDS;
    endfunction

    // stored word, upper bits zero for narrow sizes
    function automatic logic [31:0] fill_store(input access_size_t sz, input logic [31:0] v);
        if (sz == SZ_B) begin
            return v & 32'h0000_00ff;
        end
        if (sz == SZ_H) begin
            return v & 32'h0000_ffff;
        end
        return v;
    endfunction

    // loaded word by shifting the field to the top and back
    function automatic logic [31:0] extend_load(input access_size_t sz, input logic [31:0] w);
        case (sz)
            SZ_B:    return $unsigned($signed(w << 24) >>> 24);
            SZ_H:    return $unsigned($signed(w << 16) >>> 16);
            SZ_BU:   return (w << 24) >> 24;
            SZ_HU:   return (w << 16) >> 16;
            default: return w;
        endcase
    endfunction

    // called on the falling edge of a fetch cycle
    task automatic start_instr(input logic [31:0] i_pc, input logic rd, input logic wt,
                               input access_size_t sz, input logic [31:0] a,
                               input logic [31:0] v, input int mode, input int len);
        pc          = i_pc;
        read        = rd;
        write       = wt;
        func3       = sz;
        mem_address = a;
        store_data  = v;
        len_mode    = mode;
        exp_len     = len;
        chk_load    = 1'b0;
        chk_instr   = 1'b0;
    endtask

    // past the next counter_on, which also fires the checks
    task automatic end_instr();
        do begin
            @(negedge clk);
        end while (!counter_on);
        @(negedge clk);
    endtask

    task automatic run_nop(input logic [31:0] i_pc, input logic ck, input logic [31:0] e);
        start_instr(i_pc, 1'b0, 1'b0, SZ_W, 32'h0, 32'h0, LEN_EXACT, NOP_LEN);
        chk_instr = ck;
        exp_instr = e;
        end_instr();
    endtask

    task automatic run_store(input access_size_t sz, input logic [31:0] a,
                             input logic [31:0] v, input int mode);
        start_instr(32'h0, 1'b0, 1'b1, sz, a, v, mode, STORE_LEN);
        end_instr();
    endtask

    task automatic run_load(input access_size_t sz, input logic [31:0] a,
                            input logic [31:0] e, input int mode);
        start_instr(32'h0, 1'b1, 1'b0, sz, a, 32'h0, mode, LOAD_LEN);
        chk_load = 1'b1;
        exp_load = e;
        end_instr();
    endtask

    task automatic open_test();
        err_mark = errors;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != err_mark) begin
            failed++;
        end
        $display("test %-10s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "bad", errors - err_mark);
    endtask

    task automatic test_pacing();
        open_test();
        for (int i = 0; i < PACE_N; i++) begin
            run_nop(32'h0, 1'b0, 32'h0);
        end
        close_test("pacing");
    endtask

    task automatic test_store_load();
        access_size_t st_sizes [3] = '{SZ_B, SZ_H, SZ_W};
        access_size_t ld_sizes [5] = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU};
        logic [31:0]  a;
        logic [31:0]  v;
        open_test();
        for (int r = 0; r < ROUNDS; r++) begin
            // each store size, read back as a word
            for (int k = 0; k < 3; k++) begin
                a = rand_ram_addr();
                v = rand_value(r);
                run_store(st_sizes[k], a, v, LEN_EXACT);
                ram_model[word_index(a)] = fill_store(st_sizes[k], v);
                run_load(SZ_W, a, ram_model[word_index(a)], LEN_EXACT);
            end
            // one word, read back by every load size
            a = rand_ram_addr();
            v = rand_value(r);
            run_store(SZ_W, a, v, LEN_EXACT);
            ram_model[word_index(a)] = v;
            for (int k = 0; k < 5; k++) begin
                run_load(ld_sizes[k], a, extend_load(ld_sizes[k], v), LEN_EXACT);
            end
        end
        close_test("store_load");
    endtask

    task automatic test_fetch();
        logic [31:0] a;
        logic [31:0] v;
        open_test();
        for (int i = 0; i < FETCH_N; i++) begin
            a = rand_ram_addr();
            v = lcg_next();
            run_store(SZ_W, a, v, LEN_EXACT);
            ram_model[word_index(a)] = v;
            run_nop(a, 1'b1, ram_model[word_index(a)]);
        end
        close_test("fetch");
    endtask

    task automatic test_mmio();
        logic [31:0] v;
        open_test();
        for (int i = 0; i < MMIO_N; i++) begin
            v = lcg_next();
            run_store(SZ_W, 32'(`MMIO_ADDR), v, LEN_LONGER);
            mmio_model = v;
            run_load(SZ_W, 32'(`MMIO_ADDR), mmio_model, LEN_LONGER);
        end
        close_test("mmio");
    endtask

    task automatic test_unmapped();
        access_size_t ld_sizes [5] = '{SZ_B, SZ_H, SZ_W, SZ_BU, SZ_HU};
        logic [31:0]  a;
        open_test();
        for (int i = 0; i < UNMAP_N; i++) begin
            // well above the ram and the peripheral
            a = 32'h0010_0000 | (lcg_next() & 32'h000f_fffc);
            run_load(ld_sizes[(lcg_next() >> 16) % 5], a, 32'h0, LEN_ANY);
        end
        close_test("unmapped");
    endtask

    initial begin
        clk         = 1'b0;
        nrst        = 1'b0;
        pc          = 32'h0;
        mem_address = 32'h0;
        store_data  = 32'h0;
        read        = 1'b0;
        write       = 1'b0;
        func3       = SZ_W;
        len_mode    = LEN_ANY;
        exp_len     = 0;
        chk_load    = 1'b0;
        exp_load    = 32'h0;
        chk_instr   = 1'b0;
        exp_instr   = 32'h0;
        cycles      = 0;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        err_mark    = 0;
        seed        = 32'h96be_aba7;
        mmio_model  = 32'h0;

        repeat (10) @(negedge clk);
        nrst = 1'b1;
        // first counter_on passes, now in the fetch cycle
        @(negedge clk);

        test_pacing();
        test_store_load();
        test_fetch();
        test_mmio();
        test_unmapped();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/mem_pkg.sv
source/mem_bus_if.sv
source/ls_format.sv
source/mem_handler.sv
source/mem_decode.sv
source/data_ram.sv
source/mmio_reg.sv
source/mem_top.sv
tests/tb_mem_top.sv
